// ==== verilog/net_pkg.sv ====
package net_pkg;

	// field widths
	localparam int ADDR_W = 6;
	localparam int DATA_W = 8;
	localparam int CNT_W  = 8;

	// one sink per node output
	localparam int NUM_SNK = 2;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [CNT_W-1:0]  cnt_t;

	// addresses above this go to output 1, the rest to output 0
	localparam addr_t REF_ADDR = addr_t'(23);

	// four-phase link states, used by every sender and receiver
	// idle: waiting to start a transfer
	// req: request raised, waiting for the other side
	// wait_low: waiting for the other side to drop its line
	typedef enum logic [1:0]
	{
		LNK_IDLE     = 2'd0,
		LNK_REQ      = 2'd1,
		LNK_WAIT_LOW = 2'd2
	} link_state_t;

endpackage

// ==== verilog/route_node_1to2.sv ====
`timescale 1ns/1ps

module route_node_1to2
	import net_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst_n,

	// input link, node is the receiver
	input  logic               i_src_req,
	input  addr_t              i_src_addr,
	input  data_t              i_src_data,
	output logic               o_src_ack,

	// output links, node is the sender
	output logic [NUM_SNK-1:0] o_snd_req,
	output addr_t              o_snd_addr,
	output data_t              o_snd_data,
	input  logic [NUM_SNK-1:0] i_snd_ack
);

	link_state_t rcv_state;
	link_state_t snd_state;

	// holding stage
	logic  hold_valid;
	addr_t hold_addr;
	data_t hold_data;

	logic  accept;
	logic  take_hold;
	logic  route_hi;

	// destination of the message in the output stage
	logic  snd_sel;
	logic  snd_ack;

	// a new message is taken only into an empty holding stage
	assign accept    = (rcv_state == LNK_IDLE) && i_src_req && !hold_valid;
	assign take_hold = (snd_state == LNK_IDLE) && hold_valid;

	// the one routing decision of the network
	assign route_hi  = (hold_addr > REF_ADDR);

	assign snd_ack   = i_snd_ack[snd_sel];

	// receive side of the input link
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			rcv_state <= LNK_IDLE;
			o_src_ack <= 1'b0;
		end
		else
		begin
			case (rcv_state)
				LNK_IDLE:
				begin
					if (accept)
					begin
						o_src_ack <= 1'b1;
						rcv_state <= LNK_WAIT_LOW;
					end
				end
				LNK_WAIT_LOW:
				begin
					// sender has seen ack, close the handshake
					if (!i_src_req)
					begin
						o_src_ack <= 1'b0;
						rcv_state <= LNK_IDLE;
					end
				end
				default:
				begin
					o_src_ack <= 1'b0;
					rcv_state <= LNK_IDLE;
				end
			endcase
		end
	end

	// holding stage flag, set by the receiver and cleared by the sender
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			hold_valid <= 1'b0;
		else if (accept)
			hold_valid <= 1'b1;
		else if (take_hold)
			hold_valid <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			hold_addr <= i_src_addr;
			hold_data <= i_src_data;
		end
		// output stage payload stays put until the next load
		if (take_hold)
		begin
			o_snd_addr <= hold_addr;
			o_snd_data <= hold_data;
		end
	end

	// send side, drives one output link at a time
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			snd_state <= LNK_IDLE;
			snd_sel   <= 1'b0;
			o_snd_req <= '0;
		end
		else
		begin
			case (snd_state)
				LNK_IDLE:
				begin
					if (take_hold)
					begin
						snd_sel   <= route_hi;
						o_snd_req <= {{(NUM_SNK-1){1'b0}}, 1'b1} << route_hi;
						snd_state <= LNK_REQ;
					end
				end
				LNK_REQ:
				begin
					// a stalled sink keeps us here
					if (snd_ack)
					begin
						o_snd_req <= '0;
						snd_state <= LNK_WAIT_LOW;
					end
				end
				LNK_WAIT_LOW:
				begin
					if (!snd_ack)
						snd_state <= LNK_IDLE;
				end
				default:
				begin
					o_snd_req <= '0;
					snd_state <= LNK_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== verilog/msg_sink.sv ====
`timescale 1ns/1ps

module msg_sink
	import net_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_rst_n,

	// incoming four-phase link
	input  logic  i_req,
	input  addr_t i_addr,
	input  data_t i_data,
	output logic  o_ack,

	// back-pressure from the testbench
	input  logic  i_stall,

	// running statistics
	output cnt_t  o_count,
	output data_t o_checksum,
	output addr_t o_last_addr
);

	link_state_t state;
	logic        take;

	// a stalled sink leaves the request pending
	assign take = (state == LNK_IDLE) && i_req && !i_stall;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= LNK_IDLE;
			o_ack <= 1'b0;
		end
		else
		begin
			case (state)
				LNK_IDLE:
				begin
					if (take)
					begin
						o_ack <= 1'b1;
						state <= LNK_WAIT_LOW;
					end
				end
				LNK_WAIT_LOW:
				begin
					if (!i_req)
					begin
						o_ack <= 1'b0;
						state <= LNK_IDLE;
					end
				end
				default:
				begin
					o_ack <= 1'b0;
					state <= LNK_IDLE;
				end
			endcase
		end
	end

	// stats move in the same clock that ack rises
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_count     <= '0;
			o_checksum  <= '0;
			o_last_addr <= '0;
		end
		else if (take)
		begin
			o_count     <= o_count + cnt_t'(1);
			// wraps at 256 by width
			o_checksum  <= o_checksum + i_data;
			o_last_addr <= i_addr;
		end
	end

endmodule

// ==== verilog/sink_status.sv ====
`timescale 1ns/1ps

module sink_status
	import net_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_rst_n,

	// picks which sink is shown
	input  logic  i_sel,

	// statistics from every sink
	input  cnt_t  i_count     [NUM_SNK],
	input  data_t i_checksum  [NUM_SNK],
	input  addr_t i_last_addr [NUM_SNK],

	output cnt_t  o_count,
	output data_t o_checksum,
	output addr_t o_last_addr,
	output cnt_t  o_total
);

	cnt_t count_sum;

	// total delivered over all sinks
	always_comb
	begin
		count_sum = '0;
		for (int k = 0; k < NUM_SNK; k++)
			count_sum = count_sum + i_count[k];
	end

	// everything shown one clock behind the sinks
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_count     <= '0;
			o_checksum  <= '0;
			o_last_addr <= '0;
			o_total     <= '0;
		end
		else
		begin
			o_count     <= i_count[i_sel];
			o_checksum  <= i_checksum[i_sel];
			o_last_addr <= i_last_addr[i_sel];
			o_total     <= count_sum;
		end
	end

endmodule

// ==== verilog/net_top.sv ====
`timescale 1ns/1ps

module net_top
	import net_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst_n,

	// source link into the node
	input  logic               i_src_req,
	input  addr_t              i_src_addr,
	input  data_t              i_src_data,
	output logic               o_src_ack,

	// per-sink stall and status select
	input  logic [NUM_SNK-1:0] i_stall,
	input  logic               i_sel,

	// status of the selected sink
	output cnt_t               o_count,
	output data_t              o_checksum,
	output addr_t              o_last_addr,
	output cnt_t               o_total
);

	// node to sink links
	logic [NUM_SNK-1:0] snd_req;
	logic [NUM_SNK-1:0] snd_ack;
	addr_t              snd_addr;
	data_t              snd_data;

	// sink statistics
	cnt_t               snk_count     [NUM_SNK];
	data_t              snk_checksum  [NUM_SNK];
	addr_t              snk_last_addr [NUM_SNK];

	route_node_1to2 u_node
	(
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_src_req  (i_src_req),
		.i_src_addr (i_src_addr),
		.i_src_data (i_src_data),
		.o_src_ack  (o_src_ack),
		.o_snd_req  (snd_req),
		.o_snd_addr (snd_addr),
		.o_snd_data (snd_data),
		.i_snd_ack  (snd_ack)
	);

	// address and data are shared, only req and ack are per sink
	for (genvar k = 0; k < NUM_SNK; k++)
	begin : g_snk
		msg_sink u_sink
		(
			.i_clk       (i_clk),
			.i_rst_n     (i_rst_n),
			.i_req       (snd_req[k]),
			.i_addr      (snd_addr),
			.i_data      (snd_data),
			.o_ack       (snd_ack[k]),
			.i_stall     (i_stall[k]),
			.o_count     (snk_count[k]),
			.o_checksum  (snk_checksum[k]),
			.o_last_addr (snk_last_addr[k])
		);
	end

	sink_status u_status
	(
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_sel       (i_sel),
		.i_count     (snk_count),
		.i_checksum  (snk_checksum),
		.i_last_addr (snk_last_addr),
		.o_count     (o_count),
		.o_checksum  (o_checksum),
		.o_last_addr (o_last_addr),
		.o_total     (o_total)
	);

endmodule

// ==== verif/net_props.sv ====
`timescale 1ns/1ps

module net_props
	import net_pkg::*;
(
	input logic               i_clk,
	input logic               i_rst_n,
	input logic               i_src_req,
	input logic               o_src_ack,
	input logic [NUM_SNK-1:0] o_snd_req,
	input addr_t              o_snd_addr,
	input data_t              o_snd_data,
	input logic [NUM_SNK-1:0] i_snd_ack
);

	// ack only answers a pending request
	ack_after_req: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		$rose(o_src_ack) |-> $past(i_src_req)
	)
	else
		$error("o_src_ack rose while i_src_req was low");

	// payload held while a request waits for its ack
	payload_stable: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(|(o_snd_req & ~i_snd_ack)) |=> ($stable(o_snd_addr) && $stable(o_snd_data))
	)
	else
		$error("output payload changed while a request was pending");

	one_output: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		$onehot0(o_snd_req)
	)
	else
		$error("more than one output request high");

endmodule

bind route_node_1to2 net_props u_props (.*);

// ==== verif/net_tb.sv ====
`timescale 1ns/1ps

module net_tb
	import net_pkg::*;
();

	localparam int          CLK_PERIOD    = 20;
	localparam int          BLOCK_CYC     = 16;
	localparam int          ACK_CYC       = 32;
	localparam int          DRAIN_CYC     = 64;
	localparam int          MSG_BOUND_CYC = 200;
	localparam logic [31:0] SEED          = 32'h109bccb5;
	localparam string       IN_FILE       = "verif/route_input.txt";

	logic               i_clk;
	logic               i_rst_n;
	logic               i_src_req;
	addr_t              i_src_addr;
	data_t              i_src_data;
	logic               o_src_ack;
	logic [NUM_SNK-1:0] i_stall;
	logic               i_sel;
	cnt_t               o_count;
	data_t              o_checksum;
	addr_t              o_last_addr;
	cnt_t               o_total;

	// data file contents, kind 0 starts a test, 1 is a message, 2 runs the checks
	int q_kind[$];
	int q_a[$];
	int q_d[$];
	int q_s[$];
	int q_k[$];
	int n_msg;
	bit loaded;

	// expected sink statistics
	int exp_count [NUM_SNK];
	int exp_sum   [NUM_SNK];
	int exp_last  [NUM_SNK];
	int exp_total;

	int errors;
	int checks;

	net_top uut (.*);

	initial
	begin
		i_clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	task automatic check_val(input string name, input int got, input int exp);
		checks++;
		assert (got == exp)
		else
		begin
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			$display("error at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic push_item(input int kind, input int a, input int d, input int s, input int k);
		q_kind.push_back(kind);
		q_a.push_back(a);
		q_d.push_back(d);
		q_s.push_back(s);
		q_k.push_back(k);
	endtask

	task automatic load_file();
		int    fd;
		int    a;
		int    d;
		int    s;
		int    k;
		string line;
		string word;
		fd = $fopen(IN_FILE, "r");
		check_true(fd != 0, "cannot open the input data file");
		while (fd != 0 && !$feof(fd))
		begin
			line = "";
			word = "";
			void'($fgets(line, fd));
			void'($sscanf(line, "%s", word));
			if (word == "test" && $sscanf(line, "test %d", a) == 1)
				push_item(0, a, 0, 0, 0);
			else if (word == "check")
				push_item(2, 0, 0, 0, 0);
			else if (word != "" && word.getc(0) != "#"
				&& $sscanf(line, "%h %h %h %h", a, d, s, k) == 4)
			begin
				push_item(1, a, d, s, k);
				n_msg++;
			end
		end
		if (fd != 0)
			$fclose(fd);
	endtask

	// o_src_ack sampled on falling edges
	task automatic wait_ack(input logic lvl, input int limit, output bit ok);
		int n;
		n = 0;
		@(negedge i_clk);
		while (o_src_ack !== lvl && n < limit)
		begin
			@(negedge i_clk);
			n++;
		end
		ok = (o_src_ack === lvl);
	endtask

	task automatic send_msg(input addr_t a, input data_t d, input logic [NUM_SNK-1:0] st,
		input int mark, output bit blocked);
		bit ok;
		@(posedge i_clk);
		i_stall    <= st;
		i_src_addr <= a;
		i_src_data <= d;
		i_src_req  <= 1'b1;
		wait_ack(1'b1, (st != '0) ? BLOCK_CYC : ACK_CYC, ok);
		blocked = !ok;
		if (blocked)
		begin
			// both node stages full, nothing may have reached a sink
			check_val("o_total", o_total, mark % 256);
			@(posedge i_clk);
			i_stall <= '0;
			wait_ack(1'b1, ACK_CYC, ok);
		end
		check_true(ok, $sformatf("input link never acknowledged address %0d", a));
		@(posedge i_clk);
		i_src_req <= 1'b0;
		wait_ack(1'b0, ACK_CYC, ok);
		check_true(ok, "o_src_ack stayed high after req dropped");
	endtask

	task automatic check_stats();
		int n;
		n = 0;
		@(negedge i_clk);
		while (int'(o_total) != exp_total % 256 && n < DRAIN_CYC)
		begin
			@(negedge i_clk);
			n++;
		end
		check_val("o_total", o_total, exp_total % 256);
		check_val("o_src_ack", o_src_ack, 0);
		for (int s = 0; s < NUM_SNK; s++)
		begin
			@(posedge i_clk);
			i_sel <= s[0];
			// status registers lag the select by one clock
			repeat (2) @(negedge i_clk);
			check_val($sformatf("o_count[%0d]", s), o_count, exp_count[s] % 256);
			check_val($sformatf("o_checksum[%0d]", s), o_checksum, exp_sum[s]);
			check_val($sformatf("o_last_addr[%0d]", s), o_last_addr, exp_last[s]);
		end
	endtask

	initial
	begin
		int                 gap;
		int                 test_id;
		int                 test_err;
		int                 test_msgs;
		bit                 tracking;
		bit                 exp_blk;
		bit                 blocked;
		int                 hs_stalled;
		int                 total_mark;
		int                 k;
		addr_t              a;
		data_t              d;
		logic [NUM_SNK-1:0] st;

		i_rst_n    = 1'b0;
		i_src_req  = 1'b0;
		i_src_addr = '0;
		i_src_data = '0;
		i_stall    = '0;
		i_sel      = 1'b0;
		void'($urandom(SEED));
		load_file();
		loaded = 1'b1;
		repeat (2) @(posedge i_clk);
		i_rst_n <= 1'b1;

		for (int i = 0; i < q_kind.size(); i++)
		begin
			if (q_kind[i] == 0)
			begin
				test_id++;
				gap        = q_a[i];
				test_err   = errors;
				test_msgs  = 0;
				tracking   = 1'b0;
				hs_stalled = 0;
			end
			else if (q_kind[i] == 1)
			begin
				a  = addr_t'(q_a[i]);
				d  = data_t'(q_d[i]);
				st = NUM_SNK'(q_s[i]);
				k  = q_k[i] % NUM_SNK;
				check_true(q_k[i] == ((a > REF_ADDR) ? 1 : 0),
					$sformatf("data file gives sink %0d for address %0d", q_k[i], a));
				repeat ($urandom_range(gap, 0)) @(posedge i_clk);
				// a message for a stalled sink fills the node two handshakes later
				if (!tracking && st[k])
				begin
					tracking   = 1'b1;
					hs_stalled = 0;
					total_mark = exp_total;
				end
				exp_blk = tracking && (hs_stalled == 2);
				send_msg(a, d, st, total_mark, blocked);
				check_true(blocked == exp_blk, blocked
					? "input link blocked with no stalled sink ahead"
					: "input link kept accepting behind a stalled sink");
				if (blocked)
					tracking = 1'b0;
				else
					hs_stalled++;
				exp_count[k]++;
				exp_sum[k] = (exp_sum[k] + d) % 256;
				exp_last[k] = a;
				exp_total++;
				test_msgs++;
			end
			else
			begin
				@(posedge i_clk);
				i_stall <= '0;
				check_stats();
				$display("test %0d: %0d messages, %s", test_id, test_msgs,
					(errors == test_err) ? "ok" : "FAILED");
			end
		end

		$display("tests %0d, messages %0d, checks %0d, errors %0d",
			test_id, n_msg, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// bound grows with the number of messages in the file
	initial
	begin
		wait (loaded);
		#((n_msg + 1) * MSG_BOUND_CYC * CLK_PERIOD);
		$display("error at %0t: run did not finish in time", $time);
		$display("Verification failed");
		$finish;
	end

endmodule

// ==== sim.f ====
verilog/net_pkg.sv
verilog/route_node_1to2.sv
verilog/msg_sink.sv
verilog/sink_status.sv
verilog/net_top.sv
verif/net_props.sv
verif/net_tb.sv

// ==== verif/route_input.txt ====
# blocks open with "test <max idle gap>" and close with "check"
# message columns in hex: address data stall_mask expected_sink
test 0
check
test 0
00 12 0 0
17 34 0 0
18 56 0 1
37 78 0 1
check
test 0
05 ff 0 0
2a 81 0 1
17 90 0 0
3f 7f 0 1
0c a5 0 0
19 c3 0 1
check
test 0
3a 11 2 1
05 22 2 0
10 33 2 0
02 44 0 0
check
test 4
01 10 0 0
30 20 0 1
16 f0 0 0
20 0e 0 1
3e 99 0 1
08 5a 0 0
24 c7 0 1
11 3c 0 0
2f 61 0 1
14 d2 0 0
check
